// File: logic/capture_pkg.sv
/* Shared widths and types of the capture path. addr_width sets the memory depth,
   and so the window length; every counter in the design scales with it */
`default_nettype none

package capture_pkg;

    // Memory and window geometry
    localparam int addr_width = 5;
    localparam int depth      = 2 ** addr_width;

    // Sample field widths
    localparam int data_width = 16;
    localparam int dest_width = 4;
    localparam int user_width = 4;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [dest_width-1:0] dest;
        logic [user_width-1:0] user;
    } sample_t;

    // A sample with its trigger mark attached
    typedef struct packed {
        sample_t sample;
        logic    hit;
    } marked_sample_t;

    typedef enum logic {
        mode_rising,
        mode_falling
    } trigger_mode_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fill,
        st_armed,
        st_post,
        st_drain,
        st_play
    } capture_state_t;

endpackage

`default_nettype wire

// File: logic/capture_memory.sv
/* Simple dual-port RAM with one cycle of read latency. Contents are undefined
   until written, and a read of the address being written returns the old word */
`default_nettype none

module capture_memory
    import capture_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  write_enable,
    input  wire logic [addr_width-1:0] write_address,
    input  wire sample_t               write_data,
    input  wire logic [addr_width-1:0] read_address,
    output sample_t                    read_data
);

    sample_t storage [depth];

    always_ff @(posedge clock) begin
        if (write_enable) begin
            storage[write_address] <= write_data;
        end
    end

    // The read port samples its address on every edge
    always_ff @(posedge clock) begin
        read_data <= storage[read_address];
    end

endmodule

`default_nettype wire

// File: logic/trigger_detector.sv
/* Data and level are compared as unsigned values. mode and level must stay
   stable while a capture runs; the previous value is kept across captures */
`default_nettype none

module trigger_detector
    import capture_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  arst_n,
    input  wire logic                  in_valid,
    input  wire sample_t               in_sample,
    output logic                       in_ready,
    input  wire trigger_mode_t         mode,
    input  wire logic [data_width-1:0] level,
    output logic                       mid_valid,
    output marked_sample_t             mid_sample,
    input  wire logic                  mid_ready
);

    logic                  port_open;
    logic                  have_prev;
    logic [data_width-1:0] prev_data;
    logic                  rise_hit;
    logic                  fall_hit;
    logic                  accept;

    // The port stays closed until the first edge after reset release
    assign in_ready = port_open && (!mid_valid || mid_ready);
    assign accept   = in_valid && in_ready;

    // Rising marks a sample at or above level that follows one below it.
    // Falling marks a sample below level that follows one at or above it
    assign rise_hit = have_prev && (prev_data < level) && (in_sample.data >= level);
    assign fall_hit = have_prev && (prev_data >= level) && (in_sample.data < level);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            port_open <= 1'b0;
            have_prev <= 1'b0;
            mid_valid <= 1'b0;
        end else begin
            port_open <= 1'b1;
            if (accept) begin
                have_prev <= 1'b1;
                mid_valid <= 1'b1;
            end else if (mid_ready) begin
                mid_valid <= 1'b0;
            end
        end
    end

    // Sample and mark move together into the output register
    always_ff @(posedge clock) begin
        if (accept) begin
            prev_data         <= in_sample.data;
            mid_sample.sample <= in_sample;
            mid_sample.hit    <= (mode == mode_rising) ? rise_hit : fall_hit;
        end
    end

endmodule

`default_nettype wire

// File: logic/capture_buffer.sv
/* One window of depth samples per arm; pre_trigger is latched at arm. Input is
   refused from the end of the window until the next arm, so nothing is overwritten */
`default_nettype none

module capture_buffer
    import capture_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  arst_n,
    input  wire logic                  arm,
    input  wire logic [addr_width-1:0] pre_trigger,
    output logic                       busy,
    input  wire logic                  mid_valid,
    input  wire marked_sample_t        mid_sample,
    output logic                       mid_ready,
    output logic                       out_valid,
    output sample_t                    out_sample,
    output logic                       out_last,
    input  wire logic                  out_ready
);

    capture_state_t        state;
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic [addr_width-1:0] pre_count;
    logic [addr_width-1:0] fill_count;
    logic [addr_width-1:0] post_count;
    logic [addr_width:0]   play_count;
    logic                  write_enable;
    sample_t               read_data;
    logic                  read_pending;
    logic                  read_last;
    sample_t               skid_sample;
    logic                  skid_valid;
    logic                  skid_last;
    logic                  skid_next;
    logic                  out_load;
    logic                  issue;

    assign busy         = (state != st_idle);
    assign mid_ready    = (state == st_fill) || (state == st_armed) || (state == st_post);
    assign write_enable = mid_valid && mid_ready;

    // The output register takes a new sample when empty or when it transfers
    assign out_load = !out_valid || out_ready;

    // Would the skid register still hold a sample after this edge?
    assign skid_next = out_load ? (skid_valid && read_pending) : (skid_valid || read_pending);

    // A read is only issued when the word it returns is sure to find room
    assign issue = ((state == st_drain) || (state == st_play))
                   && (play_count != (addr_width + 1)'(depth))
                   && !skid_next;

    capture_memory u_memory (
        .clock        (clock),
        .write_enable (write_enable),
        .write_address(wr_ptr),
        .write_data   (mid_sample.sample),
        .read_address (rd_ptr),
        .read_data    (read_data)
    );

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_idle;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            pre_count  <= '0;
            fill_count <= '0;
            post_count <= '0;
            play_count <= '0;
        end else begin
            if (write_enable) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr     <= rd_ptr + 1'b1;
                play_count <= play_count + 1'b1;
            end
            case (state)
                st_idle: begin
                    if (arm) begin
                        pre_count  <= pre_trigger;
                        fill_count <= pre_trigger;
                        play_count <= '0;
                        state      <= (pre_trigger == '0) ? st_armed : st_fill;
                    end
                end
                // Hits are ignored until the pre-trigger part has been written
                st_fill: begin
                    if (write_enable) begin
                        fill_count <= fill_count - 1'b1;
                        if (fill_count == addr_width'(1)) begin
                            state <= st_armed;
                        end
                    end
                end
                st_armed: begin
                    if (write_enable && mid_sample.hit) begin
                        rd_ptr     <= wr_ptr - pre_count;
                        post_count <= addr_width'(depth - 1) - pre_count;
                        state      <= (pre_count == addr_width'(depth - 1)) ? st_drain : st_post;
                    end
                end
                st_post: begin
                    if (write_enable) begin
                        post_count <= post_count - 1'b1;
                        if (post_count == addr_width'(1)) begin
                            state <= st_drain;
                        end
                    end
                end
                st_drain: begin
                    state <= st_play;
                end
                st_play: begin
                    if (out_valid && out_ready && out_last) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Playback flags. The skid slot is always older than the word on the read port
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            read_pending <= 1'b0;
            read_last    <= 1'b0;
            skid_valid   <= 1'b0;
            skid_last    <= 1'b0;
            out_valid    <= 1'b0;
            out_last     <= 1'b0;
        end else begin
            read_pending <= issue;
            read_last    <= issue && (play_count == (addr_width + 1)'(depth - 1));
            if (out_load) begin
                if (skid_valid) begin
                    out_valid  <= 1'b1;
                    out_last   <= skid_last;
                    skid_valid <= read_pending;
                    skid_last  <= read_last;
                end else begin
                    out_valid <= read_pending;
                    out_last  <= read_pending && read_last;
                end
            end else if (read_pending) begin
                skid_valid <= 1'b1;
                skid_last  <= read_last;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (out_load) begin
            if (skid_valid) begin
                out_sample  <= skid_sample;
                skid_sample <= read_data;
            end else if (read_pending) begin
                out_sample <= read_data;
            end
        end else if (read_pending) begin
            // Stalled output, so the word just read is parked
            skid_sample <= read_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/capture_top.sv
/* Configuration inputs must stay stable while busy is high. Every stream moves
   a sample on an edge where valid and ready are both high */
`default_nettype none

module capture_top
    import capture_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  arst_n,
    input  wire logic                  in_valid,
    input  wire sample_t               in_sample,
    output logic                       in_ready,
    output logic                       out_valid,
    output sample_t                    out_sample,
    output logic                       out_last,
    input  wire logic                  out_ready,
    input  wire logic                  arm,
    input  wire trigger_mode_t         mode,
    input  wire logic [data_width-1:0] level,
    input  wire logic [addr_width-1:0] pre_trigger,
    output logic                       busy
);

    // Marked samples from the detector to the buffer
    logic           mid_valid;
    marked_sample_t mid_sample;
    logic           mid_ready;

    trigger_detector u_detector (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .in_ready  (in_ready),
        .mode      (mode),
        .level     (level),
        .mid_valid (mid_valid),
        .mid_sample(mid_sample),
        .mid_ready (mid_ready)
    );

    capture_buffer u_buffer (
        .clock      (clock),
        .arst_n     (arst_n),
        .arm        (arm),
        .pre_trigger(pre_trigger),
        .busy       (busy),
        .mid_valid  (mid_valid),
        .mid_sample (mid_sample),
        .mid_ready  (mid_ready),
        .out_valid  (out_valid),
        .out_sample (out_sample),
        .out_last   (out_last),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// File: tests/capture_top_asserts.sv
/* Stream and state checks inside capture_buffer, active only while arst_n is high.
   failures counts every assertion that fired */
`default_nettype none

module capture_top_asserts
    import capture_pkg::*;
(
    input wire logic           clock,
    input wire logic           arst_n,
    input wire capture_state_t state,
    input wire logic           busy,
    input wire logic           mid_valid,
    input wire marked_sample_t mid_sample,
    input wire logic           mid_ready,
    input wire logic           out_valid,
    input wire sample_t        out_sample,
    input wire logic           out_last,
    input wire logic           out_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // A stalled transfer keeps its valid and its payload
    mid_hold: assert property (@(posedge clock) disable iff (!arst_n)
        mid_valid && !mid_ready |=> mid_valid && $stable(mid_sample))
    else begin
        failures++;
        $error("mid stream dropped or changed a stalled sample");
    end

    out_hold: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_sample) && $stable(out_last))
    else begin
        failures++;
        $error("out stream dropped or changed a stalled sample");
    end

    // Output words only appear during playback
    out_in_play: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid |-> state == st_play)
    else begin
        failures++;
        $error("out_valid is high in state %0d outside playback", state);
    end

    // Busy may only fall with the last output transfer
    busy_until_last: assert property (@(posedge clock) disable iff (!arst_n)
        busy && !(out_valid && out_ready && out_last) |=> busy)
    else begin
        failures++;
        $error("busy fell before the last output transfer");
    end

endmodule

`default_nettype wire

// File: tests/capture_top_tb.sv
/* Directed captures checked against a model of the trigger and window rules.
   Inputs change on the falling edge, where the outputs are also sampled */
`default_nettype none

module capture_top_tb
    import capture_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic                  clock;
    logic                  arst_n;
    logic                  in_valid;
    sample_t               in_sample;
    logic                  in_ready;
    logic                  out_valid;
    sample_t               out_sample;
    logic                  out_last;
    logic                  out_ready;
    logic                  arm;
    trigger_mode_t         mode;
    logic [data_width-1:0] level;
    logic [addr_width-1:0] pre_trigger;
    logic                  busy;

    logic [31:0]           lfsr;
    logic [data_width-1:0] prev_data;
    logic                  have_prev;
    sample_t               accepted[$];
    int                    checks;
    int                    errors;
    int                    timeout_cycles = 4000;

    capture_top dut (.*);

    bind capture_buffer capture_top_asserts u_asserts (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int random_bits(input int count);
        int r;
        r = 0;
        for (int b = 0; b < count; b++) begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    task automatic compare_sample(input string name, input sample_t got, input sample_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, want);
        end
    endtask

    // Shapes are 0 for a ramp, 1 for random data, 2 for a short early pulse then a step
    function automatic sample_t make_sample(input int shape, input int n);
        sample_t s;
        s.dest = dest_width'(n);
        s.user = user_width'(random_bits(user_width));
        case (shape)
            0: s.data = data_width'(n * 64);
            1: s.data = data_width'(random_bits(data_width));
            default: s.data = data_width'(((n >= 3 && n < 6) || n >= 20) ? 'h2000 + n : 'h0100 + n);
        endcase
        return s;
    endfunction

    // Edge crossing against the previous accepted value, unsigned
    function automatic logic crosses(input logic [data_width-1:0] cur);
        if (!have_prev) begin
            return 1'b0;
        end
        if (mode == mode_rising) begin
            return prev_data < level && cur >= level;
        end
        return prev_data >= level && cur < level;
    endfunction

    task automatic run_capture(input string title, input trigger_mode_t new_mode,
                               input int new_level, input int pre, input int shape,
                               input bit gaps, input bit stalls);
        int trig;
        int sent;
        int got;
        int waited;
        int errors_before;
        bit took;
        bit complete;
        trig = -1;
        sent = 0;
        got = 0;
        waited = 0;
        took = 1'b0;
        complete = 1'b0;
        errors_before = errors;
        accepted.delete();
        @(negedge clock);
        mode = new_mode;
        level = data_width'(new_level);
        pre_trigger = addr_width'(pre);
        arm = 1'b1;
        @(negedge clock);
        arm = 1'b0;
        compare_flag("busy", busy, 1'b1);
        while (got < depth) begin
            // A sample still waiting for in_ready is held as it is
            if (!in_valid || took) begin
                in_valid = !complete && (!gaps || random_bits(2) != 0);
                if (in_valid) begin
                    in_sample = make_sample(shape, sent);
                    sent++;
                end
            end
            took = in_valid && in_ready;
            if (took) begin
                if (trig < 0 && accepted.size() >= pre && crosses(in_sample.data)) begin
                    trig = accepted.size();
                end
                have_prev = 1'b1;
                prev_data = in_sample.data;
                accepted.push_back(in_sample);
                complete = trig >= 0 && accepted.size() >= trig - pre + depth;
            end
            out_ready = !stalls || random_bits(1) != 0;
            if (out_valid && out_ready) begin
                if (!complete) begin
                    errors++;
                    $display("Output sample appeared before the window was complete");
                end else begin
                    compare_sample("out_sample", out_sample, accepted[trig - pre + got]);
                    compare_flag("out_last", out_last, got == depth - 1);
                end
                got++;
            end
            waited++;
            if (waited > timeout_cycles) begin
                $display("Timeout in %s: %0d of %0d samples out", title, got, depth);
                $display("TESTBENCH FAILED");
                $finish;
            end
            @(negedge clock);
        end
        compare_flag("busy", busy, 1'b0);
        compare_flag("out_valid", out_valid, 1'b0);
        $display("%s: %0d errors", title, errors - errors_before);
    endtask

    initial begin
        lfsr = 32'd92137;
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_sample = '0;
        out_ready = 1'b0;
        arm = 1'b0;
        mode = mode_rising;
        level = '0;
        pre_trigger = '0;
        have_prev = 1'b0;
        prev_data = '0;
        checks = 0;
        errors = 0;
        repeat (10) @(negedge clock);
        compare_flag("in_ready", in_ready, 1'b0);
        arst_n = 1'b1;
        compare_flag("busy", busy, 1'b0);
        compare_flag("out_valid", out_valid, 1'b0);
        run_capture("Rising ramp, pre-trigger 8", mode_rising, 'h0800, 8, 0, 1'b0, 1'b0);
        run_capture("Falling random data", mode_falling, 'h8000, 16, 1, 1'b0, 1'b0);
        run_capture("Early crossing ignored", mode_rising, 'h1000, 12, 2, 1'b0, 1'b0);
        run_capture("Output back-pressure", mode_rising, 'h4000, 20, 1, 1'b0, 1'b1);
        run_capture("Input gaps, pre-trigger 0", mode_falling, 'h6000, 0, 1, 1'b1, 1'b1);
        run_capture("Input gaps, full pre-trigger", mode_rising, 'h6000, depth - 1, 1,
                    1'b1, 1'b0);
        errors = errors + dut.u_buffer.u_asserts.failures;
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: capture_top.f
logic/capture_pkg.sv
logic/capture_memory.sv
logic/trigger_detector.sv
logic/capture_buffer.sv
logic/capture_top.sv
tests/capture_top_asserts.sv
tests/capture_top_tb.sv

// File: Makefile
# Verilator build and run of the capture path testbench
VERILATOR ?= verilator
TOP       ?= capture_top_tb
FILELIST  ?= capture_top.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
PASS_TEXT ?= TESTBENCH PASSED
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

.PHONY: run build lint clean

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
